//--- synth_ctrl_pkg.sv
`default_nettype none

package synth_ctrl_pkg;

    // upper nibble of midi status bytes
    localparam logic [3:0] STATUS_NOTE_OFF = 4'h8;
    localparam logic [3:0] STATUS_NOTE_ON  = 4'h9;
    localparam logic [3:0] STATUS_CTRL     = 4'hB;
    localparam logic [3:0] STATUS_PRG      = 4'hC;
    localparam logic [3:0] STATUS_PITCH    = 4'hE;
    localparam logic [3:0] STATUS_SYS      = 4'hF;

    localparam int DATA_W = 7;   // midi data byte payload
    localparam int BEND_W = 14;

    localparam logic [DATA_W-1:0] CC_ALL_NOTES_OFF = 7'd123;

    // parser to allocator message kinds
    localparam logic [1:0] KIND_NOTE_ON  = 2'd1;
    localparam logic [1:0] KIND_NOTE_OFF = 2'd2;
    localparam logic [1:0] KIND_ALL_OFF  = 2'd3;

    typedef struct packed {
        logic [DATA_W-1:0] key;
        logic [DATA_W-1:0] velocity;
    } note_body_t;

    typedef struct packed {
        logic [DATA_W-1:0] number;
        logic [DATA_W-1:0] value;
    } ctrl_body_t;

    // same two data bytes, read per status type
    typedef union packed {
        note_body_t note;
        ctrl_body_t ctrl;
    } msg_body_u;

    typedef struct packed {
        logic       valid;
        logic [1:0] kind;
        msg_body_u  body;
    } note_msg_t;

    typedef struct packed {
        logic              valid;
        logic              on;
        logic [DATA_W-1:0] key;
        logic [DATA_W-1:0] velocity;
    } note_event_t;

    typedef struct packed {
        logic      valid;
        msg_body_u body;
    } ctrl_event_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] prog;
    } prg_event_t;

    typedef struct packed {
        logic              valid;
        logic [BEND_W-1:0] bend;
    } pitch_event_t;

endpackage

`default_nettype wire

//--- midi_uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module midi_uart_rx #(
    parameter int CLKS_PER_BIT = 800
) (
    input  logic       CLOCK_25,
    input  logic       reset_reg_N,
    input  logic       midi_rxd,
    output logic       rx_valid,
    output logic [7:0] rx_byte
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_DATA  = 2'd2;
    localparam logic [1:0] ST_STOP  = 2'd3;

    logic             rxd_meta;
    logic             rxd_sync;
    logic             rxd_prev;
    logic [1:0]       state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_cnt;
    logic [7:0]       shift_reg;
    logic             fall;
    logic             half_bit;
    logic             full_bit;

    assign fall     = rxd_prev && !rxd_sync;
    assign half_bit = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign full_bit = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge CLOCK_25) begin
        if (!reset_reg_N) begin
            rxd_meta <= 1'b1;   // idle line is high
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
            state    <= ST_IDLE;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rxd_meta <= midi_rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
            rx_valid <= 1'b0;
            clk_cnt  <= clk_cnt + 1'b1;
            case (state)
                ST_IDLE: begin
                    clk_cnt <= '0;
                    if (fall) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    if (half_bit) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rxd_sync ? ST_IDLE : ST_DATA;   // glitch, not a start bit
                    end
                end
                ST_DATA: begin
                    if (full_bit) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= ST_STOP;
                        end
                    end
                end
                default: begin
                    if (full_bit) begin
                        rx_valid <= rxd_sync;   // framing error drops the byte
                        state    <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLOCK_25) begin
        if (state == ST_DATA && full_bit) begin
            shift_reg <= {rxd_sync, shift_reg[7:1]};   // lsb first
        end
        if (state == ST_STOP && full_bit) begin
            rx_byte <= shift_reg;
        end
    end

endmodule

`default_nettype wire

//--- midi_msg_parser.sv
`timescale 1ns/1ps
`default_nettype none

module midi_msg_parser import synth_ctrl_pkg::*; (
    input  logic         CLOCK_25,
    input  logic         reset_reg_N,
    input  logic         rx_valid,
    input  logic [7:0]   rx_byte,
    input  logic [3:0]   midi_ch,
    output note_msg_t    note_msg,
    output ctrl_event_t  ctrl_evt,
    output prg_event_t   prg_evt,
    output pitch_event_t pitch_evt
);

    logic              status_ok;   // running status is a channel message
    logic [7:0]        run_status;
    logic              byte_cnt;
    logic [DATA_W-1:0] data0;
    logic [3:0]        cmd;
    logic              is_chan_status;
    logic              is_common;
    logic              is_data;
    logic              one_byte;
    logic              msg_done;
    logic              our_ch;
    logic              msg_v;
    logic              ctrl_v;
    logic              prg_v;
    logic              pitch_v;
    logic [1:0]        msg_kind;
    msg_body_u         msg_body;

    assign cmd            = run_status[7:4];
    assign is_chan_status = rx_valid && rx_byte[7] && (rx_byte[7:4] != STATUS_SYS);
    assign is_common      = rx_valid && (rx_byte[7:3] == 5'b11110);   // f0..f7
    assign is_data        = rx_valid && !rx_byte[7] && status_ok;
    assign one_byte       = (cmd == STATUS_PRG);
    assign msg_done       = is_data && (one_byte || byte_cnt);
    assign our_ch         = (run_status[3:0] == midi_ch);

    always_ff @(posedge CLOCK_25) begin
        if (!reset_reg_N) begin
            status_ok <= 1'b0;
            byte_cnt  <= 1'b0;
            msg_v     <= 1'b0;
            ctrl_v    <= 1'b0;
            prg_v     <= 1'b0;
            pitch_v   <= 1'b0;
        end else begin
            msg_v   <= 1'b0;
            ctrl_v  <= 1'b0;
            prg_v   <= 1'b0;
            pitch_v <= 1'b0;
            if (is_chan_status) begin
                status_ok <= 1'b1;
                byte_cnt  <= 1'b0;
            end else if (is_common) begin
                status_ok <= 1'b0;   // sysex data bytes fall through unused
                byte_cnt  <= 1'b0;
            end else if (is_data) begin
                byte_cnt <= !one_byte && !byte_cnt;
            end
            if (msg_done && our_ch) begin
                case (cmd)
                    STATUS_NOTE_ON, STATUS_NOTE_OFF: begin
                        msg_v <= 1'b1;
                    end
                    STATUS_CTRL: begin
                        ctrl_v <= 1'b1;
                        msg_v  <= (data0 == CC_ALL_NOTES_OFF);
                    end
                    STATUS_PRG: begin
                        prg_v <= 1'b1;
                    end
                    STATUS_PITCH: begin
                        pitch_v <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge CLOCK_25) begin
        if (is_chan_status) begin
            run_status <= rx_byte;
        end
        if (is_data && !byte_cnt) begin
            data0 <= rx_byte[DATA_W-1:0];
        end
        if (msg_done) begin
            msg_body.note <= '{key: data0, velocity: rx_byte[DATA_W-1:0]};
            if (cmd == STATUS_CTRL) begin
                msg_kind <= KIND_ALL_OFF;
            end else if (cmd == STATUS_NOTE_ON && rx_byte[DATA_W-1:0] != '0) begin
                msg_kind <= KIND_NOTE_ON;
            end else begin
                msg_kind <= KIND_NOTE_OFF;   // includes note on with zero velocity
            end
        end
    end

    assign note_msg  = '{valid: msg_v, kind: msg_kind, body: msg_body};
    assign ctrl_evt  = '{valid: ctrl_v, body: msg_body};
    assign prg_evt   = '{valid: prg_v, prog: msg_body.ctrl.value};
    assign pitch_evt = '{valid: pitch_v, bend: {msg_body.ctrl.value, msg_body.ctrl.number}};

endmodule

`default_nettype wire

//--- voice_allocator.sv
`timescale 1ns/1ps
`default_nettype none

module voice_allocator import synth_ctrl_pkg::*; #(
    parameter int VOICES  = 8,
    parameter int VOICE_W = 3
) (
    input  logic               CLOCK_25,
    input  logic               reset_reg_N,
    input  note_msg_t          note_msg,
    input  logic [VOICES-1:0]  voice_free,
    output logic [VOICES-1:0]  keys_on,
    output note_event_t        note_evt,
    output logic [VOICE_W-1:0] note_voice,
    output logic [VOICE_W:0]   active_keys
);

    logic [VOICES-1:0]  free_meta;
    logic [VOICES-1:0]  free_sync;
    logic [DATA_W-1:0]  voice_key [VOICES];
    logic [VOICE_W-1:0] rank [VOICES];       // 0 is the newest held note
    logic [VOICE_W-1:0] rank_nxt [VOICES];
    logic [VOICES-1:0]  held_nxt;
    logic [VOICE_W-1:0] free_idx;
    logic [VOICE_W-1:0] idle_idx;
    logic [VOICE_W-1:0] old_idx;
    logic [VOICE_W-1:0] off_idx;
    logic [VOICE_W-1:0] on_idx;
    logic               free_found;
    logic               idle_found;
    logic               off_found;
    logic               is_on;
    logic               is_off;
    logic               is_all_off;
    logic               evt_v;
    logic               evt_on;
    logic [DATA_W-1:0]  evt_key;
    logic [DATA_W-1:0]  evt_vel;

    function automatic logic [VOICE_W:0] count_held(input logic [VOICES-1:0] held);
        logic [VOICE_W:0] n;
        n = '0;
        for (int i = 0; i < VOICES; i++) begin
            n = n + {{VOICE_W{1'b0}}, held[i]};
        end
        return n;
    endfunction

    assign is_on      = note_msg.valid && (note_msg.kind == KIND_NOTE_ON);
    assign is_off     = note_msg.valid && (note_msg.kind == KIND_NOTE_OFF);
    assign is_all_off = note_msg.valid && (note_msg.kind == KIND_ALL_OFF);

    // downward scan so the lowest index wins
    always_comb begin
        free_found = 1'b0;
        idle_found = 1'b0;
        off_found  = 1'b0;
        free_idx   = '0;
        idle_idx   = '0;
        off_idx    = '0;
        old_idx    = '0;
        for (int v = VOICES - 1; v >= 0; v--) begin
            if (!keys_on[v] && free_sync[v]) begin
                free_found = 1'b1;
                free_idx   = VOICE_W'(v);
            end
            if (!keys_on[v]) begin
                idle_found = 1'b1;
                idle_idx   = VOICE_W'(v);
            end
            if (keys_on[v] && voice_key[v] == note_msg.body.note.key) begin
                off_found = 1'b1;
                off_idx   = VOICE_W'(v);
            end
            if (keys_on[v] && rank[v] == VOICE_W'(VOICES - 1)) begin
                old_idx = VOICE_W'(v);   // only reached when every voice is held
            end
        end
    end

    assign on_idx = free_found ? free_idx : (idle_found ? idle_idx : old_idx);

    always_comb begin
        held_nxt = keys_on;
        rank_nxt = rank;
        if (is_on) begin
            for (int v = 0; v < VOICES; v++) begin
                if (keys_on[v] && VOICE_W'(v) != on_idx) begin
                    rank_nxt[v] = rank[v] + 1'b1;
                end
            end
            held_nxt[on_idx] = 1'b1;
            rank_nxt[on_idx] = '0;
        end else if (is_off && off_found) begin
            held_nxt[off_idx] = 1'b0;
            for (int v = 0; v < VOICES; v++) begin
                if (keys_on[v] && rank[v] > rank[off_idx]) begin
                    rank_nxt[v] = rank[v] - 1'b1;   // close the gap in age order
                end
            end
        end else if (is_all_off) begin
            held_nxt = '0;
        end
    end

    always_ff @(posedge CLOCK_25) begin
        if (!reset_reg_N) begin
            keys_on     <= '0;
            active_keys <= '0;
            evt_v       <= 1'b0;
            for (int v = 0; v < VOICES; v++) begin
                rank[v] <= '0;
            end
        end else begin
            keys_on     <= held_nxt;
            active_keys <= count_held(held_nxt);
            rank        <= rank_nxt;
            evt_v       <= is_on || (is_off && off_found);
        end
    end

    always_ff @(posedge CLOCK_25) begin
        free_meta <= voice_free;
        free_sync <= free_meta;
        if (is_on) begin
            voice_key[on_idx] <= note_msg.body.note.key;   // stolen voice just takes the new key
        end
        if (note_msg.valid) begin
            note_voice <= is_on ? on_idx : off_idx;
            evt_on     <= is_on;
            evt_key    <= note_msg.body.note.key;
            evt_vel    <= note_msg.body.note.velocity;
        end
    end

    assign note_evt = '{valid: evt_v, on: evt_on, key: evt_key, velocity: evt_vel};

endmodule

`default_nettype wire

//--- synth_controller.sv
`timescale 1ns/1ps
`default_nettype none

module synth_controller import synth_ctrl_pkg::*; #(
    parameter int VOICES       = 8,
    parameter int VOICE_W      = 3,
    parameter int CLKS_PER_BIT = 800   // 31250 baud at 25 MHz
) (
    input  logic               CLOCK_25,
    input  logic               reset_reg_N,
    input  logic               midi_rxd,
    input  logic [3:0]         midi_ch,
    input  logic [VOICES-1:0]  voice_free,
    output logic [VOICES-1:0]  keys_on,
    output note_event_t        note_evt,
    output logic [VOICE_W-1:0] note_voice,
    output logic [VOICE_W:0]   active_keys,
    output ctrl_event_t        ctrl_evt,
    output prg_event_t         prg_evt,
    output pitch_event_t       pitch_evt
);

    logic       rx_valid;
    logic [7:0] rx_byte;
    note_msg_t  note_msg;

    midi_uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_midi_uart_rx (
        .CLOCK_25    (CLOCK_25),
        .reset_reg_N (reset_reg_N),
        .midi_rxd    (midi_rxd),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte)
    );

    midi_msg_parser i_midi_msg_parser (
        .CLOCK_25    (CLOCK_25),
        .reset_reg_N (reset_reg_N),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .midi_ch     (midi_ch),
        .note_msg    (note_msg),
        .ctrl_evt    (ctrl_evt),
        .prg_evt     (prg_evt),
        .pitch_evt   (pitch_evt)
    );

    voice_allocator #(
        .VOICES  (VOICES),
        .VOICE_W (VOICE_W)
    ) i_voice_allocator (
        .CLOCK_25    (CLOCK_25),
        .reset_reg_N (reset_reg_N),
        .note_msg    (note_msg),
        .voice_free  (voice_free),
        .keys_on     (keys_on),
        .note_evt    (note_evt),
        .note_voice  (note_voice),
        .active_keys (active_keys)
    );

endmodule

`default_nettype wire

//--- synth_controller_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module synth_controller_asserts import synth_ctrl_pkg::*; #(
    parameter int VOICES  = 8,
    parameter int VOICE_W = 3
) (
    input  logic               CLOCK_25,
    input  logic               reset_reg_N,
    input  logic [VOICES-1:0]  keys_on,
    input  note_event_t        note_evt,
    input  logic [VOICE_W:0]   active_keys
);

    // never more held notes than voices
    a_active_max: assert property (@(posedge CLOCK_25) disable iff (!reset_reg_N)
        active_keys <= (VOICE_W+1)'(VOICES))
        else $error("active_keys is larger than the number of voices");

    a_active_count: assert property (@(posedge CLOCK_25) disable iff (!reset_reg_N)
        32'(active_keys) == $countones(keys_on))
        else $error("active_keys differs from the number of set bits in keys_on");

    // one message per byte time, so events never touch
    a_evt_pulse: assert property (@(posedge CLOCK_25) disable iff (!reset_reg_N)
        note_evt.valid |=> !note_evt.valid)
        else $error("note_evt.valid stayed high for more than one cycle");

endmodule

`default_nettype wire

//--- tb_synth_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_synth_controller import synth_ctrl_pkg::*;;

    localparam int VOICES      = 8;
    localparam int VOICE_W     = 3;
    localparam int BIT_CLKS    = 16;
    localparam int EVT_TIMEOUT = 400;    // cycles
    localparam int WATCHDOG    = 2000000;

    localparam logic [3:0] EV_NOTE  = 4'd1;
    localparam logic [3:0] EV_CTRL  = 4'd2;
    localparam logic [3:0] EV_PRG   = 4'd3;
    localparam logic [3:0] EV_PITCH = 4'd4;

    logic               CLOCK_25 = 1'b0;
    logic               reset_reg_N;
    logic               midi_rxd;
    logic [3:0]         midi_ch;
    logic [VOICES-1:0]  voice_free;
    logic [VOICES-1:0]  keys_on;
    note_event_t        note_evt;
    logic [VOICE_W-1:0] note_voice;
    logic [VOICE_W:0]   active_keys;
    ctrl_event_t        ctrl_evt;
    prg_event_t         prg_evt;
    pitch_event_t       pitch_evt;

    logic [31:0]       exp_q[$];     // kind in [31:28], payload in [17:0]
    logic [31:0]       obs_q[$];
    logic [7:0]        m_status;
    logic              m_ok;
    logic              m_second;
    logic [6:0]        m_d0;
    logic [VOICES-1:0] m_held;
    logic [6:0]        m_key [VOICES];
    int                m_stamp [VOICES];
    int                stamp_ctr;
    int                errors;
    int                timeouts;
    int                extra_events;

    synth_controller #(
        .VOICES       (VOICES),
        .VOICE_W      (VOICE_W),
        .CLKS_PER_BIT (BIT_CLKS)
    ) i_synth_controller (
        .CLOCK_25    (CLOCK_25),
        .reset_reg_N (reset_reg_N),
        .midi_rxd    (midi_rxd),
        .midi_ch     (midi_ch),
        .voice_free  (voice_free),
        .keys_on     (keys_on),
        .note_evt    (note_evt),
        .note_voice  (note_voice),
        .active_keys (active_keys),
        .ctrl_evt    (ctrl_evt),
        .prg_evt     (prg_evt),
        .pitch_evt   (pitch_evt)
    );

    bind voice_allocator synth_controller_asserts #(
        .VOICES  (VOICES),
        .VOICE_W (VOICE_W)
    ) i_allocator_asserts (
        .CLOCK_25    (CLOCK_25),
        .reset_reg_N (reset_reg_N),
        .keys_on     (keys_on),
        .note_evt    (note_evt),
        .active_keys (active_keys)
    );

    always #10 CLOCK_25 = ~CLOCK_25;

    function automatic logic [31:0] make_evt(input logic [3:0] kind, input logic [17:0] payload);
        return {kind, 10'd0, payload};
    endfunction

    function automatic int model_count();
        int n;
        n = 0;
        for (int v = 0; v < VOICES; v++) begin
            n = n + int'(m_held[v]);
        end
        return n;
    endfunction

    // outputs are stable at the falling edge
    always @(negedge CLOCK_25) begin
        if (reset_reg_N) begin
            if (note_evt.valid) begin
                obs_q.push_back(make_evt(EV_NOTE,
                    {note_voice, note_evt.on, note_evt.key, note_evt.velocity}));
            end
            if (ctrl_evt.valid) begin
                obs_q.push_back(make_evt(EV_CTRL,
                    {4'd0, ctrl_evt.body.ctrl.number, ctrl_evt.body.ctrl.value}));
            end
            if (prg_evt.valid) begin
                obs_q.push_back(make_evt(EV_PRG, {11'd0, prg_evt.prog}));
            end
            if (pitch_evt.valid) begin
                obs_q.push_back(make_evt(EV_PITCH, {4'd0, pitch_evt.bend}));
            end
        end
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic model_note_on(input logic [6:0] key, input logic [6:0] vel);
        int pick;
        pick = -1;
        for (int v = VOICES - 1; v >= 0; v--) begin
            if (!m_held[v] && voice_free[v]) pick = v;
        end
        if (pick < 0) begin
            for (int v = VOICES - 1; v >= 0; v--) begin
                if (!m_held[v]) pick = v;
            end
        end
        if (pick < 0) begin
            pick = 0;
            for (int v = 1; v < VOICES; v++) begin
                if (m_stamp[v] < m_stamp[pick]) pick = v;   // steal the oldest
            end
        end
        stamp_ctr++;
        m_held[pick]  = 1'b1;
        m_key[pick]   = key;
        m_stamp[pick] = stamp_ctr;
        exp_q.push_back(make_evt(EV_NOTE, {3'(pick), 1'b1, key, vel}));
    endtask

    task automatic model_note_off(input logic [6:0] key, input logic [6:0] vel);
        int pick;
        pick = -1;
        for (int v = VOICES - 1; v >= 0; v--) begin
            if (m_held[v] && m_key[v] == key) pick = v;
        end
        if (pick >= 0) begin
            m_held[pick] = 1'b0;
            exp_q.push_back(make_evt(EV_NOTE, {3'(pick), 1'b0, key, vel}));
        end
    endtask

    task automatic complete_msg(input logic [6:0] d0, input logic [6:0] d1);
        if (m_status[3:0] == midi_ch) begin
            case (m_status[7:4])
                STATUS_NOTE_ON: begin
                    if (d1 != '0) model_note_on(d0, d1);
                    else model_note_off(d0, d1);
                end
                STATUS_NOTE_OFF: model_note_off(d0, d1);
                STATUS_CTRL: begin
                    exp_q.push_back(make_evt(EV_CTRL, {4'd0, d0, d1}));
                    if (d0 == CC_ALL_NOTES_OFF) m_held = '0;
                end
                STATUS_PRG: exp_q.push_back(make_evt(EV_PRG, {11'd0, d1}));
                STATUS_PITCH: exp_q.push_back(make_evt(EV_PITCH, 18'(d1) * 18'd128 + 18'(d0)));
                default: begin
                end
            endcase
        end
    endtask

    task automatic feed_model(input logic [7:0] b);
        if (b < 8'hF8) begin   // realtime bytes leave everything alone
            if (b[7] && b[7:4] != STATUS_SYS) begin
                m_status = b;
                m_ok     = 1'b1;
                m_second = 1'b0;
            end else if (b[7]) begin
                m_ok     = 1'b0;
                m_second = 1'b0;
            end else if (m_ok) begin
                if (m_status[7:4] == STATUS_PRG) begin
                    complete_msg(b[6:0], b[6:0]);
                end else if (!m_second) begin
                    m_d0     = b[6:0];
                    m_second = 1'b1;
                end else begin
                    m_second = 1'b0;
                    complete_msg(m_d0, b[6:0]);
                end
            end
        end
    endtask

    task automatic drive_bit(input logic v);
        midi_rxd <= v;
        repeat (BIT_CLKS) @(posedge CLOCK_25);
    endtask

    task automatic send_byte(input logic [7:0] b);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(1'b1);
        feed_model(b);
    endtask

    task automatic await_event(output bit seen);
        int n;
        n    = 0;
        seen = (obs_q.size() > 0);
        while (!seen && n < EVT_TIMEOUT) begin
            @(negedge CLOCK_25);
            n++;
            seen = (obs_q.size() > 0);
        end
        if (!seen) begin
            timeouts++;
            $display("timeout at %0t: an expected output event never arrived", $time);
        end
    endtask

    task automatic compare_event(input logic [31:0] got, input logic [31:0] exp);
        check("event kind", 32'(got[31:28]), 32'(exp[31:28]));
        case (exp[31:28])
            EV_NOTE: begin
                check("note voice", 32'(got[17:15]), 32'(exp[17:15]));
                check("note on flag", 32'(got[14]), 32'(exp[14]));
                check("note key", 32'(got[13:7]), 32'(exp[13:7]));
                check("note velocity", 32'(got[6:0]), 32'(exp[6:0]));
            end
            EV_CTRL: begin
                check("controller number", 32'(got[13:7]), 32'(exp[13:7]));
                check("controller value", 32'(got[6:0]), 32'(exp[6:0]));
            end
            EV_PRG: check("program", 32'(got[6:0]), 32'(exp[6:0]));
            default: check("pitch bend", 32'(got[13:0]), 32'(exp[13:0]));
        endcase
    endtask

    // match events, then look at the key table while the line is idle
    task automatic settle();
        logic [31:0] exp_e;
        bit          seen;
        while (exp_q.size() > 0) begin
            exp_e = exp_q.pop_front();
            await_event(seen);
            if (seen) compare_event(obs_q.pop_front(), exp_e);
        end
        repeat (8) @(negedge CLOCK_25);
        if (obs_q.size() > 0) begin
            $display("unexpected output event at %0t: %0d extra, first %h",
                     $time, obs_q.size(), obs_q[0]);
            extra_events += obs_q.size();
            obs_q.delete();
        end
        check("keys_on", 32'(keys_on), 32'(m_held));
        check("active_keys", 32'(active_keys), 32'(model_count()));
        @(posedge CLOCK_25);
        voice_free <= VOICES'($urandom);
        repeat (6) @(posedge CLOCK_25);   // through the synchronizer before the next byte
    endtask

    task automatic send_msg(input logic [7:0] status, input logic [6:0] d0, input logic [6:0] d1);
        send_byte(status);
        send_byte({1'b0, d0});
        if (status[7:4] != STATUS_PRG) send_byte({1'b0, d1});
        settle();
    endtask

    initial begin : watchdog
        repeat (WATCHDOG) @(posedge CLOCK_25);
        $display("simulation ran past the watchdog limit");
        $display("Test failed");
        $finish;
    end

    initial begin : main_seq
        int          seed_ret;
        logic [6:0]  key;
        logic [3:0]  other_ch;
        seed_ret     = $urandom(32'h38ad6879);
        midi_ch      = 4'($urandom);
        midi_rxd     = 1'b1;
        voice_free   = '1;
        reset_reg_N  = 1'b0;
        m_ok         = 1'b0;
        m_second     = 1'b0;
        m_held       = '0;
        stamp_ctr    = 0;
        errors       = 0;
        timeouts     = 0;
        extra_events = 0;
        repeat (10) @(posedge CLOCK_25);
        reset_reg_N <= 1'b1;
        repeat (4) @(posedge CLOCK_25);
        check("keys_on after reset", 32'(keys_on), 32'd0);

        // random note traffic on a small key range so releases hit
        for (int n = 0; n < 60; n++) begin
            key = 7'(60 + $urandom_range(11));
            if ($urandom_range(2) != 0) begin
                send_msg({STATUS_NOTE_ON, midi_ch}, key, 7'($urandom_range(127, 1)));
            end else begin
                send_msg({STATUS_NOTE_OFF, midi_ch}, key, 7'($urandom));
            end
        end

        // fill every voice, then steal
        send_msg({STATUS_CTRL, midi_ch}, CC_ALL_NOTES_OFF, 7'd0);
        for (int n = 0; n < VOICES + 5; n++) begin
            send_msg({STATUS_NOTE_ON, midi_ch}, 7'(20 + n), 7'($urandom_range(127, 1)));
        end
        send_msg({STATUS_NOTE_ON, midi_ch}, 7'd26, 7'd0);
        send_msg({STATUS_NOTE_OFF, midi_ch}, 7'd21, 7'd64);   // voice was stolen

        for (int n = 0; n < 20; n++) begin
            key      = 7'($urandom_range(127));
            other_ch = midi_ch ^ 4'($urandom_range(15, 1));
            send_msg({STATUS_NOTE_ON, other_ch}, key, 7'($urandom_range(127, 1)));
            send_byte(8'hF0);
            for (int k = 0; k < 4; k++) begin
                send_byte({1'b0, 7'($urandom)});
            end
            send_byte(8'hF7);
            send_byte({1'b0, 7'($urandom)});   // no running status left
            settle();
            send_byte({STATUS_NOTE_ON, midi_ch});
            send_byte({1'b0, key});
            send_byte(8'hF8 | 8'($urandom_range(7)));
            send_byte({1'b0, 7'($urandom_range(127, 1))});
            settle();
            for (int k = 0; k < 3; k++) begin
                send_byte({1'b0, 7'(key + 7'(k))});
                send_byte({1'b0, 7'($urandom_range(1))});
                settle();
            end
        end

        for (int n = 0; n < 30; n++) begin
            send_msg({STATUS_CTRL, midi_ch}, 7'($urandom), 7'($urandom));
            send_msg({STATUS_NOTE_ON, midi_ch}, 7'($urandom), 7'($urandom_range(127, 1)));
        end
        send_msg({STATUS_CTRL, midi_ch}, CC_ALL_NOTES_OFF, 7'd0);
        check("keys_on after all notes off", 32'(keys_on), 32'd0);

        for (int n = 0; n < 20; n++) begin
            other_ch = ($urandom_range(1) != 0) ? midi_ch : 4'($urandom);
            send_msg({STATUS_PRG, other_ch}, 7'($urandom), 7'd0);
            send_msg({STATUS_PITCH, midi_ch}, 7'($urandom), 7'($urandom));
            send_byte({1'b0, 7'($urandom)});   // second bend by running status
            send_byte({1'b0, 7'($urandom)});
            settle();
        end

        $display("errors: %0d value mismatches, %0d timeouts, %0d unexpected events",
                 errors, timeouts, extra_events);
        if (errors == 0 && timeouts == 0 && extra_events == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
synth_ctrl_pkg.sv
midi_uart_rx.sv
midi_msg_parser.sv
voice_allocator.sv
synth_controller.sv
synth_controller_asserts.sv
tb_synth_controller.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the synth controller testbench
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_synth_controller \
    -f list.f

./obj_dir/Vtb_synth_controller | tee sim.log

if grep -q "^Test passed$" sim.log; then
    exit 0
else
    exit 1
fi
